//--- verilog.f
+incdir+source
source/mem_bus_pkg.sv
source/mem_req_if.sv
source/mem_port.sv
source/bus_arbiter.sv
source/axi_master.sv
source/mem_bus_top.sv
dv/axi_slave_model.sv
dv/tb_mem_bus.sv

//--- dv/tb_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

module tb_mem_bus;

	localparam int TIMEOUT_CYCLES = 10000;   // ~200 transfers of 40 cycles, plus reset

	logic                   aclk = 1'b0;
	logic                   i_reset;
	logic                   i_inst_req;
	logic [`MEM_ADDR_W-1:0] i_inst_addr;
	logic                   i_data_req;
	logic [`MEM_ADDR_W-1:0] i_data_addr;
	logic                   i_data_we;
	logic [`MEM_STRB_W-1:0] i_data_wstrb;
	logic [`MEM_DATA_W-1:0] i_data_wdata;
	wire                    o_inst_ack;
	wire                    o_data_ack;
	wire  [`MEM_DATA_W-1:0] o_inst_rdata;
	wire  [`MEM_DATA_W-1:0] o_data_rdata;
	wire  [`MEM_ADDR_W-1:0] o_araddr;
	wire  [`MEM_ADDR_W-1:0] o_awaddr;
	wire  [`MEM_DATA_W-1:0] o_wdata;
	wire  [`MEM_STRB_W-1:0] o_wstrb;
	wire                    o_arvalid, o_rready, o_awvalid, o_wvalid, o_bready;
	wire                    i_arready, i_rvalid, i_awready, i_wready, i_bvalid;
	wire  [`MEM_DATA_W-1:0] i_rdata;
	wire  [`MEM_ADDR_W-1:0] last_raddr;
	wire  [`MEM_ADDR_W-1:0] last_waddr;

	logic [`MEM_DATA_W-1:0] shadow [0:255];
	logic [`MEM_ADDR_W-1:0] exp_inst_paddr;
	logic [`MEM_DATA_W-1:0] exp_inst_rdata;
	logic [`MEM_ADDR_W-1:0] exp_data_paddr;
	logic [`MEM_DATA_W-1:0] exp_data_rdata;
	logic                   exp_data_we;
	logic                   inst_ack_q = 1'b0;
	logic                   data_ack_q = 1'b0;
	time                    inst_ack_time;
	time                    data_ack_time;
	int                     cycle_count = 0;
	logic                   ar_hold_q = 1'b0;
	logic                   aw_hold_q = 1'b0;
	logic                   w_hold_q = 1'b0;
	logic [`MEM_ADDR_W-1:0] araddr_q;
	logic [`MEM_ADDR_W-1:0] awaddr_q;
	logic [`MEM_DATA_W+`MEM_STRB_W-1:0] wbeat_q;

	mem_bus_top dut_i (.*);

	axi_slave_model slave_i (
		.aclk (aclk), .i_reset (i_reset),
		.i_araddr (o_araddr), .i_arvalid (o_arvalid), .o_arready (i_arready),
		.o_rdata (i_rdata), .o_rvalid (i_rvalid), .i_rready (o_rready),
		.i_awaddr (o_awaddr), .i_awvalid (o_awvalid), .o_awready (i_awready),
		.i_wdata (o_wdata), .i_wstrb (o_wstrb), .i_wvalid (o_wvalid), .o_wready (i_wready),
		.o_bvalid (i_bvalid), .i_bready (o_bready),
		.o_last_raddr (last_raddr), .o_last_waddr (last_waddr)
	);

	always #10 aclk = ~aclk;

	// unmapped segments drop their top bits, everything else passes through
	function automatic logic [`MEM_ADDR_W-1:0] ref_translate(input logic [`MEM_ADDR_W-1:0] va);
		if (va[`MEM_ADDR_W-1 -: `SEG_W] == `SEG_KSEG0 || va[`MEM_ADDR_W-1 -: `SEG_W] == `SEG_KSEG1)
			return {{`SEG_W{1'b0}}, va[`MEM_ADDR_W-`SEG_W-1:0]};
		else
			return va;
	endfunction

	function automatic logic [`MEM_DATA_W-1:0] merge_strobe(input logic [`MEM_DATA_W-1:0] old_w,
		input logic [`MEM_DATA_W-1:0] new_w, input logic [`MEM_STRB_W-1:0] strb);
		logic [`MEM_DATA_W-1:0] merged;
		merged = old_w;
		for (int b = 0; b < `MEM_STRB_W; b++) begin
			if (strb[b])
				merged[8*b +: 8] = new_w[8*b +: 8];
		end
		return merged;
	endfunction

	function automatic logic [`MEM_DATA_W-1:0] fill_word(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
	endfunction

	// random segment and offset, word index forced
	function automatic logic [`MEM_ADDR_W-1:0] make_va(input int idx);
		logic [`MEM_ADDR_W-1:0] va;
		va = $urandom;
		va[9:2] = idx[7:0];
		return va;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_idle_outputs();
		assert ({o_inst_ack, o_data_ack, o_arvalid, o_awvalid, o_wvalid, o_rready, o_bready} === 7'b0)
		else fail_run($sformatf("Mismatch at %0t: control outputs not all low after reset", $time));
	endtask

	task automatic inst_read(input logic [`MEM_ADDR_W-1:0] va);
		@(posedge aclk);
		#1;
		exp_inst_paddr = ref_translate(va);
		exp_inst_rdata = shadow[exp_inst_paddr[9:2]];
		i_inst_addr    = va;
		i_inst_req     = 1'b1;
		do @(posedge aclk); while (o_inst_ack !== 1'b1);
		#1 i_inst_req = 1'b0;
		do @(posedge aclk); while (o_inst_ack !== 1'b0);   // four-phase close
	endtask

	task automatic data_access(input logic [`MEM_ADDR_W-1:0] va, input logic we,
		input logic [`MEM_STRB_W-1:0] strb, input logic [`MEM_DATA_W-1:0] wdata);
		@(posedge aclk);
		#1;
		exp_data_paddr = ref_translate(va);
		exp_data_we    = we;
		if (we)
			shadow[exp_data_paddr[9:2]] = merge_strobe(shadow[exp_data_paddr[9:2]], wdata, strb);
		exp_data_rdata = shadow[exp_data_paddr[9:2]];
		i_data_addr    = va;
		i_data_we      = we;
		i_data_wstrb   = strb;
		i_data_wdata   = wdata;
		i_data_req     = 1'b1;
		do @(posedge aclk); while (o_data_ack !== 1'b1);
		#1 i_data_req = 1'b0;
		do @(posedge aclk); while (o_data_ack !== 1'b0);
	endtask

	// comparator, fires on each rising ack
	always @(posedge aclk) begin
		if (o_inst_ack === 1'b1 && !inst_ack_q) begin
			inst_ack_time = $time;
			assert (o_inst_rdata === exp_inst_rdata)
			else fail_run($sformatf("Mismatch at %0t: inst rdata %h, expected %h",
				$time, o_inst_rdata, exp_inst_rdata));
			assert (last_raddr === exp_inst_paddr)
			else fail_run($sformatf("Mismatch at %0t: inst araddr %h, expected %h",
				$time, last_raddr, exp_inst_paddr));
		end
		if (o_data_ack === 1'b1 && !data_ack_q) begin
			data_ack_time = $time;
			if (exp_data_we) begin
				assert (last_waddr === exp_data_paddr)
				else fail_run($sformatf("Mismatch at %0t: awaddr %h, expected %h",
					$time, last_waddr, exp_data_paddr));
			end else begin
				assert (o_data_rdata === exp_data_rdata)
				else fail_run($sformatf("Mismatch at %0t: data rdata %h, expected %h",
					$time, o_data_rdata, exp_data_rdata));
				assert (last_raddr === exp_data_paddr)
				else fail_run($sformatf("Mismatch at %0t: data araddr %h, expected %h",
					$time, last_raddr, exp_data_paddr));
			end
		end
		inst_ack_q = (o_inst_ack === 1'b1);
		data_ack_q = (o_data_ack === 1'b1);
	end

	// a valid waiting for ready must hold itself and its fields
	always @(posedge aclk) begin
		if (ar_hold_q)
			assert (o_arvalid === 1'b1 && o_araddr === araddr_q)
			else fail_run("AXI read address valid dropped or changed before arready");
		if (aw_hold_q)
			assert (o_awvalid === 1'b1 && o_awaddr === awaddr_q)
			else fail_run("AXI write address valid dropped or changed before awready");
		if (w_hold_q)
			assert (o_wvalid === 1'b1 && {o_wdata, o_wstrb} === wbeat_q)
			else fail_run("AXI write data valid dropped or changed before wready");
		ar_hold_q = !i_reset && o_arvalid === 1'b1 && i_arready !== 1'b1;
		aw_hold_q = !i_reset && o_awvalid === 1'b1 && i_awready !== 1'b1;
		w_hold_q  = !i_reset && o_wvalid === 1'b1 && i_wready !== 1'b1;
		araddr_q  = o_araddr;
		awaddr_q  = o_awaddr;
		wbeat_q   = {o_wdata, o_wstrb};
	end

	always @(posedge aclk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run("Timeout: the transfers did not finish within the cycle limit");
	end

	initial begin
		logic [`MEM_ADDR_W-1:0] va;
		logic [`MEM_ADDR_W-1:0] wr_va [0:9];
		void'($urandom(53288));
		i_reset      = 1'b1;
		i_inst_req   = 1'b0;
		i_inst_addr  = '0;
		i_data_req   = 1'b0;
		i_data_addr  = '0;
		i_data_we    = 1'b0;
		i_data_wstrb = '0;
		i_data_wdata = '0;
		for (int i = 0; i < 256; i++) begin
			shadow[i]      = fill_word(i);
			slave_i.mem[i] = shadow[i];
		end
		repeat (16) begin
			@(posedge aclk);
			#1;
			check_idle_outputs();
		end
		i_reset = 1'b0;
		@(posedge aclk);
		#1;
		check_idle_outputs();

		// fetch through kseg0, kseg1 and kuseg
		for (int s = 0; s < 3; s++) begin
			for (int k = 0; k < 4; k++) begin
				va = make_va($urandom_range(127));
				va[`MEM_ADDR_W-1 -: `SEG_W] = (s == 0) ? `SEG_KSEG0 :
					(s == 1) ? `SEG_KSEG1 : 3'($urandom_range(3));
				inst_read(va);
			end
		end

		// writes only ever land in the upper half of the memory
		for (int k = 0; k < 10; k++) begin
			wr_va[k] = make_va(128 + k * 12);
			data_access(wr_va[k], 1'b1, 4'($urandom), $urandom);
		end
		for (int k = 0; k < 10; k++)
			data_access(wr_va[k], 1'b0, '0, '0);

		// both sides raised in the same cycle, fetch wins
		fork
			inst_read(make_va($urandom_range(127)));
			data_access(make_va(128 + $urandom_range(127)), 1'b0, '0, '0);
		join
		assert (inst_ack_time < data_ack_time)
		else fail_run("Fetch was not served before the simultaneous data access");

		fork
			for (int k = 0; k < 75; k++)
				inst_read(make_va($urandom_range(127)));
			for (int k = 0; k < 75; k++) begin
				if ($urandom_range(1))
					data_access(make_va(128 + $urandom_range(127)), 1'b1, 4'($urandom), $urandom);
				else
					data_access(make_va($urandom_range(255)), 1'b0, '0, '0);
			end
		join

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

// single-beat axi slave over a 256-word memory, random handshake delays
module axi_slave_model (
	input  wire                    aclk,
	input  wire                    i_reset,
	input  wire  [`MEM_ADDR_W-1:0] i_araddr,
	input  wire                    i_arvalid,
	output logic                   o_arready,
	output logic [`MEM_DATA_W-1:0] o_rdata,
	output logic                   o_rvalid,
	input  wire                    i_rready,
	input  wire  [`MEM_ADDR_W-1:0] i_awaddr,
	input  wire                    i_awvalid,
	output logic                   o_awready,
	input  wire  [`MEM_DATA_W-1:0] i_wdata,
	input  wire  [`MEM_STRB_W-1:0] i_wstrb,
	input  wire                    i_wvalid,
	output logic                   o_wready,
	output logic                   o_bvalid,
	input  wire                    i_bready,
	output logic [`MEM_ADDR_W-1:0] o_last_raddr,
	output logic [`MEM_ADDR_W-1:0] o_last_waddr
);

	logic [`MEM_DATA_W-1:0] mem [0:255];   // word index is addr[9:2]
	logic [`MEM_ADDR_W-1:0] raddr;
	logic [`MEM_ADDR_W-1:0] waddr;
	logic [`MEM_DATA_W-1:0] wdata;
	logic [`MEM_STRB_W-1:0] wstrb;
	int unsigned            aw_dly;
	int unsigned            w_dly;
	logic                   aw_left;
	logic                   w_left;

	initial begin
		o_arready    = 1'b0;
		o_rdata      = '0;
		o_rvalid     = 1'b0;
		o_awready    = 1'b0;
		o_wready     = 1'b0;
		o_bvalid     = 1'b0;
		o_last_raddr = '0;
		o_last_waddr = '0;
	end

	// read: ar, then r
	always begin
		@(posedge aclk);
		if (!i_reset && i_arvalid) begin
			repeat ($urandom_range(3)) @(posedge aclk);
			#1 o_arready = 1'b1;
			@(posedge aclk);
			raddr = i_araddr;   // taken on the handshake edge
			repeat ($urandom_range(3)) @(posedge aclk);
			#1;
			o_arready    = 1'b0;
			o_last_raddr = raddr;
			o_rdata      = mem[raddr[9:2]];
			o_rvalid     = 1'b1;
			do @(posedge aclk); while (!i_rready);
			#1 o_rvalid = 1'b0;
		end
	end

	// write: aw and w with their own delays, then b
	always begin
		@(posedge aclk);
		if (!i_reset && i_awvalid && i_wvalid) begin
			aw_dly  = $urandom_range(3);
			w_dly   = $urandom_range(3);
			aw_left = 1'b1;
			w_left  = 1'b1;
			while (aw_left || w_left) begin
				#1;
				o_awready = aw_left && aw_dly == 0;
				o_wready  = w_left && w_dly == 0;
				@(posedge aclk);
				if (o_awready) begin
					waddr   = i_awaddr;
					aw_left = 1'b0;
				end
				if (o_wready) begin
					wdata  = i_wdata;
					wstrb  = i_wstrb;
					w_left = 1'b0;
				end
				if (aw_dly != 0)
					aw_dly--;
				if (w_dly != 0)
					w_dly--;
			end
			repeat ($urandom_range(3)) @(posedge aclk);
			#1;
			o_awready    = 1'b0;
			o_wready     = 1'b0;
			o_last_waddr = waddr;
			for (int b = 0; b < `MEM_STRB_W; b++) begin
				if (wstrb[b])
					mem[waddr[9:2]][8*b +: 8] = wdata[8*b +: 8];
			end
			o_bvalid = 1'b1;
			do @(posedge aclk); while (!i_bready);
			#1 o_bvalid = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/mem_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

module mem_bus_top (
	input  wire                    aclk,
	input  wire                    i_reset,

	// instruction fetch, read only
	input  wire                    i_inst_req,
	input  wire  [`MEM_ADDR_W-1:0] i_inst_addr,
	output logic                   o_inst_ack,
	output logic [`MEM_DATA_W-1:0] o_inst_rdata,

	// data load/store
	input  wire                    i_data_req,
	input  wire  [`MEM_ADDR_W-1:0] i_data_addr,
	input  wire                    i_data_we,
	input  wire  [`MEM_STRB_W-1:0] i_data_wstrb,
	input  wire  [`MEM_DATA_W-1:0] i_data_wdata,
	output logic                   o_data_ack,
	output logic [`MEM_DATA_W-1:0] o_data_rdata,

	// axi master
	output logic [`MEM_ADDR_W-1:0] o_araddr,
	output logic                   o_arvalid,
	input  wire                    i_arready,
	input  wire  [`MEM_DATA_W-1:0] i_rdata,
	input  wire                    i_rvalid,
	output logic                   o_rready,
	output logic [`MEM_ADDR_W-1:0] o_awaddr,
	output logic                   o_awvalid,
	input  wire                    i_awready,
	output logic [`MEM_DATA_W-1:0] o_wdata,
	output logic [`MEM_STRB_W-1:0] o_wstrb,
	output logic                   o_wvalid,
	input  wire                    i_wready,
	input  wire                    i_bvalid,
	output logic                   o_bready
);

	mem_req_if inst_req ();
	mem_req_if data_req ();
	mem_req_if axi_req ();

	// write inputs left open on the fetch side
	mem_port #(.CAN_WRITE(1'b0)) inst_side (
		.aclk    (aclk),
		.i_reset (i_reset),
		.i_req   (i_inst_req),
		.i_addr  (i_inst_addr),
		.i_we    (),
		.i_wstrb (),
		.i_wdata (),
		.o_ack   (o_inst_ack),
		.o_rdata (o_inst_rdata),
		.bus     (inst_req.requester)
	);

	mem_port #(.CAN_WRITE(1'b1)) data_side (
		.aclk    (aclk),
		.i_reset (i_reset),
		.i_req   (i_data_req),
		.i_addr  (i_data_addr),
		.i_we    (i_data_we),
		.i_wstrb (i_data_wstrb),
		.i_wdata (i_data_wdata),
		.o_ack   (o_data_ack),
		.o_rdata (o_data_rdata),
		.bus     (data_req.requester)
	);

	bus_arbiter arbiter (
		.aclk     (aclk),
		.i_reset  (i_reset),
		.inst_bus (inst_req.responder),
		.data_bus (data_req.responder),
		.mem_bus  (axi_req.requester)
	);

	axi_master axi_master_i (
		.aclk      (aclk),
		.i_reset   (i_reset),
		.o_araddr  (o_araddr),
		.o_arvalid (o_arvalid),
		.i_arready (i_arready),
		.i_rdata   (i_rdata),
		.i_rvalid  (i_rvalid),
		.o_rready  (o_rready),
		.o_awaddr  (o_awaddr),
		.o_awvalid (o_awvalid),
		.i_awready (i_awready),
		.o_wdata   (o_wdata),
		.o_wstrb   (o_wstrb),
		.o_wvalid  (o_wvalid),
		.i_wready  (i_wready),
		.i_bvalid  (i_bvalid),
		.o_bready  (o_bready),
		.bus       (axi_req.responder)
	);

endmodule

`default_nettype wire

//--- source/axi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

module axi_master (
	input  wire                    aclk,
	input  wire                    i_reset,

	// ar
	output logic [`MEM_ADDR_W-1:0] o_araddr,
	output logic                   o_arvalid,
	input  wire                    i_arready,
	// r
	input  wire  [`MEM_DATA_W-1:0] i_rdata,
	input  wire                    i_rvalid,
	output logic                   o_rready,
	// aw
	output logic [`MEM_ADDR_W-1:0] o_awaddr,
	output logic                   o_awvalid,
	input  wire                    i_awready,
	// w
	output logic [`MEM_DATA_W-1:0] o_wdata,
	output logic [`MEM_STRB_W-1:0] o_wstrb,
	output logic                   o_wvalid,
	input  wire                    i_wready,
	// b, response code ignored
	input  wire                    i_bvalid,
	output logic                   o_bready,

	mem_req_if.responder           bus
);

	localparam logic [2:0] s_idle    = 3'd0;
	localparam logic [2:0] s_rd_addr = 3'd1;
	localparam logic [2:0] s_rd_data = 3'd2;
	localparam logic [2:0] s_wr_req  = 3'd3;   // aw and w in flight
	localparam logic [2:0] s_wr_resp = 3'd4;

	logic [2:0]             state;
	logic                   aw_pend;
	logic                   w_pend;
	logic [`MEM_ADDR_W-1:0] addr_q;

	always_ff @(posedge aclk) begin
		if (i_reset) begin
			state   <= s_idle;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (bus.valid && bus.we) begin
						state   <= s_wr_req;
						aw_pend <= 1'b1;   // both channels rise together
						w_pend  <= 1'b1;
					end else if (bus.valid) begin
						state <= s_rd_addr;
					end
				end
				s_rd_addr: begin
					if (i_arready)
						state <= s_rd_data;
				end
				s_rd_data: begin
					if (i_rvalid)
						state <= s_idle;
				end
				s_wr_req: begin
					// each channel finishes on its own ready
					if (i_awready)
						aw_pend <= 1'b0;
					if (i_wready)
						w_pend <= 1'b0;
					if (!aw_pend && !w_pend)
						state <= s_wr_resp;
				end
				s_wr_resp: begin
					if (i_bvalid)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// payload latched when the request is taken
	always_ff @(posedge aclk) begin
		if (state == s_idle && bus.valid) begin
			addr_q  <= bus.addr;
			o_wdata <= bus.wdata;
			o_wstrb <= bus.wstrb;
		end
	end

	assign o_araddr  = addr_q;
	assign o_awaddr  = addr_q;
	assign o_arvalid = (state == s_rd_addr);
	assign o_rready  = (state == s_rd_data);
	assign o_awvalid = aw_pend;
	assign o_wvalid  = w_pend;
	assign o_bready  = (state == s_wr_resp);

	assign bus.rdata = i_rdata;
	assign bus.done  = (o_rready && i_rvalid) || (o_bready && i_bvalid);

	a_ar_hold: assert property (@(posedge aclk) disable iff (i_reset)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

	a_aw_hold: assert property (@(posedge aclk) disable iff (i_reset)
		o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));

	a_w_hold: assert property (@(posedge aclk) disable iff (i_reset)
		o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wstrb));

	a_done_pulse: assert property (@(posedge aclk) disable iff (i_reset)
		bus.done |=> !bus.done);

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

module bus_arbiter (
	input wire           aclk,
	input wire           i_reset,

	mem_req_if.responder inst_bus,
	mem_req_if.responder data_bus,
	mem_req_if.requester mem_bus
);

	logic busy;      // grant locked until done
	logic owner;     // 0 inst, 1 data
	logic sel_data;

	// fetch side wins a tie
	assign sel_data = busy ? owner : !inst_bus.valid;

	assign mem_bus.valid = sel_data ? data_bus.valid : inst_bus.valid;
	assign mem_bus.we    = sel_data ? data_bus.we    : inst_bus.we;
	assign mem_bus.addr  = sel_data ? data_bus.addr  : inst_bus.addr;
	assign mem_bus.wstrb = sel_data ? data_bus.wstrb : inst_bus.wstrb;
	assign mem_bus.wdata = sel_data ? data_bus.wdata : inst_bus.wdata;

	// steer result back to the winner only
	assign inst_bus.done  = mem_bus.done & !sel_data;
	assign data_bus.done  = mem_bus.done & sel_data;
	assign inst_bus.rdata = sel_data ? '0 : mem_bus.rdata;
	assign data_bus.rdata = sel_data ? mem_bus.rdata : '0;

	always_ff @(posedge aclk) begin
		if (i_reset) begin
			busy  <= 1'b0;
			owner <= 1'b0;
		end else if (!busy) begin
			if (mem_bus.valid) begin
				busy  <= 1'b1;
				owner <= sel_data;
			end
		end else if (mem_bus.done) begin
			busy <= 1'b0;   // free again next cycle
		end
	end

	// a locked grant keeps the steered request steady
	a_owner_locked: assert property (@(posedge aclk) disable iff (i_reset)
		busy && !mem_bus.done |=>
			$stable({mem_bus.we, mem_bus.addr, mem_bus.wstrb, mem_bus.wdata}));

	// the granted port keeps its request up until done
	a_owner_holds: assert property (@(posedge aclk) disable iff (i_reset)
		busy |-> mem_bus.valid);

endmodule

`default_nettype wire

//--- source/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

module mem_port import mem_bus_pkg::*; #(
	parameter bit CAN_WRITE = 1'b1
) (
	input  wire                    aclk,
	input  wire                    i_reset,

	// core side, four-phase
	input  wire                    i_req,
	input  wire  [`MEM_ADDR_W-1:0] i_addr,   // virtual
	input  wire                    i_we,
	input  wire  [`MEM_STRB_W-1:0] i_wstrb,
	input  wire  [`MEM_DATA_W-1:0] i_wdata,
	output logic                   o_ack,
	output logic [`MEM_DATA_W-1:0] o_rdata,

	mem_req_if.requester           bus
);

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_busy = 2'd1;   // request out on the bus
	localparam logic [1:0] s_ack  = 2'd2;   // waiting for req to drop

	logic [1:0]             state;
	vaddr_u                 va_q;
	logic                   we_q;
	logic [`MEM_STRB_W-1:0] wstrb_q;
	logic [`MEM_DATA_W-1:0] wdata_q;
	logic                   is_unmapped;

	always_ff @(posedge aclk) begin
		if (i_reset) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: begin
					// ack is low here, so a high req is always a new one
					if (i_req)
						state <= s_busy;
				end
				s_busy: begin
					if (bus.done)
						state <= s_ack;
				end
				s_ack: begin
					if (!i_req)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// request capture and read data hold
	always_ff @(posedge aclk) begin
		if (state == s_idle && i_req) begin
			va_q.flat <= i_addr;
			we_q      <= CAN_WRITE && i_we;   // fetch side never writes
			wstrb_q   <= CAN_WRITE ? i_wstrb : '0;
			wdata_q   <= CAN_WRITE ? i_wdata : '0;
		end
		if (state == s_busy && bus.done)
			o_rdata <= bus.rdata;
	end

	// kseg0/kseg1 map straight onto the low 512 MB
	assign is_unmapped = (va_q.seg_off.seg == `SEG_KSEG0) ||
		(va_q.seg_off.seg == `SEG_KSEG1);

	assign bus.addr  = is_unmapped ? {{`SEG_W{1'b0}}, va_q.seg_off.offset} : va_q.flat;
	assign bus.valid = (state == s_busy);
	assign bus.we    = we_q;
	assign bus.wstrb = wstrb_q;
	assign bus.wdata = wdata_q;

	assign o_ack = (state == s_ack);

	// core must still hold req when its transfer completes
	a_ack_with_req: assert property (@(posedge aclk) disable iff (i_reset)
		$rose(o_ack) |-> i_req);

endmodule

`default_nettype wire

//--- source/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_config.svh"

// single request channel between port, arbiter and axi master
interface mem_req_if;

	logic                   valid;
	logic                   we;
	logic [`MEM_ADDR_W-1:0] addr;    // physical
	logic [`MEM_STRB_W-1:0] wstrb;
	logic [`MEM_DATA_W-1:0] wdata;
	logic [`MEM_DATA_W-1:0] rdata;   // valid only with done
	logic                   done;    // one cycle pulse

	modport requester (
		output valid, we, addr, wstrb, wdata,
		input  rdata, done
	);

	modport responder (
		input  valid, we, addr, wstrb, wdata,
		output rdata, done
	);

	modport monitor (
		input valid, we, addr, wstrb, wdata, rdata, done
	);

endinterface

`default_nettype wire

//--- source/mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_config.svh"

package mem_bus_pkg;

	// one address word, read flat or as segment plus offset
	typedef union packed {
		logic [`MEM_ADDR_W-1:0] flat;
		struct packed {
			logic [`SEG_W-1:0]             seg;     // kuseg / kseg0 / kseg1 / kseg2 ...
			logic [`MEM_ADDR_W-`SEG_W-1:0] offset;
		} seg_off;
	} vaddr_u;

endpackage

`default_nettype wire

//--- source/mem_bus_config.svh
`ifndef MEM_BUS_CONFIG_SVH
`define MEM_BUS_CONFIG_SVH

// bus widths, one full word per beat
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// top address bits select the segment
`define SEG_W 3

// unmapped segments
`define SEG_KSEG0 3'b100    // cached
`define SEG_KSEG1 3'b101    // uncached

`endif
